//--- qpu_exu_vectors.txt
// kind test a b c  (kind 1 instr: a=word b=stall  kind 2 event: a=time b=mask c=data)
// kind 3 closes a run  kind 0 ends the list
00000001 00000002 41001234 00000000 00000000
00000001 00000002 11105678 00000000 00000000
00000001 00000002 1200FFFF 00000000 00000000
00000001 00000002 23120000 00000000 00000000
00000001 00000002 5000000A 00000000 00000000
00000001 00000002 60300001 00000000 00000000
00000001 00000002 70000000 00000000 00000000
00000002 00000003 0000000A 00000001 00005677
00000001 00000002 10100005 00000000 00000000
00000001 00000002 34010000 00000000 00000000
00000001 00000002 50000014 00000000 00000000
00000001 00000002 60400002 00000000 00000000
00000001 00000002 70000000 00000000 00000000
00000002 00000003 00000014 00000002 0000A988
00000001 00000006 84000001 00000000 00000000
00000001 00000006 F0401234 00000000 00000000
00000001 00000006 15400010 00000000 00000000
00000001 00000006 5000001E 00000000 00000000
00000001 00000006 60500080 00000000 00000000
00000001 00000006 70000000 00000000 00000000
00000002 00000006 0000001E 00000080 0000A998
00000003 00000003 00000000 00000000 00000000
00000001 00000004 110000A1 00000000 00000000
00000001 00000004 5000000A 00000000 00000000
00000001 00000004 60100001 00000000 00000000
00000001 00000004 70000000 00000000 00000000
00000002 00000004 0000000A 00000001 000000A1
00000001 00000004 50000014 00000000 00000000
00000001 00000004 70000000 00000000 00000000
00000002 00000004 00000014 00000001 000000A1
00000001 00000004 5000001E 00000000 00000000
00000001 00000004 70000000 00000000 00000000
00000002 00000004 0000001E 00000001 000000A1
00000001 00000004 50000028 00000000 00000000
00000001 00000004 70000000 00000000 00000000
00000002 00000004 00000028 00000001 000000A1
00000001 00000005 50000032 00000001 00000000
00000001 00000005 60100010 00000000 00000000
00000001 00000005 70000000 00000000 00000000
00000002 00000005 00000032 00000010 000000A1
00000003 00000005 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000

//--- src.f
qpu_pkg.sv
qpu_exu_decode.sv
qpu_exu_regfile.sv
qpu_exu_alu.sv
qpu_exu_queue.sv
qpu_exu.sv
tb_qpu_exu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_qpu_exu
FLAGS     ?= --binary --timing
OBJ_DIR   ?= obj_dir

SRCS := $(shell cat src.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) src.f
	$(VERILATOR) $(FLAGS) -f src.f --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN) qpu_exu_vectors.txt
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_qpu_exu.sv
`timescale 1ns/1ps

module tb_qpu_exu;

  import qpu_pkg::*;

  localparam int REC_W   = 5;
  localparam int MAX_REC = 64;
  localparam int NTEST   = 7;

  logic        clk = 1'b0;
  logic        i_reset;
  logic        i_valid;
  instr_t      i_instr;
  logic        i_trigger;
  time_t       i_trigger_clk;
  logic        o_ready;
  logic        o_clk_ena;
  event_mask_t o_event_valid;
  event_data_t o_event_data;

  logic [31:0] vec [MAX_REC*REC_W];
  time_t       exp_time [$];
  event_mask_t exp_mask [$];
  event_data_t exp_data [$];
  int          exp_test [$];
  int          err_cnt  [NTEST];
  logic        used     [NTEST];
  logic        reported [NTEST];
  int          n_rec;
  int          cycles;
  int          limit;
  int          seed;
  int          ev_idx;
  logic        triggered;
  logic        prev_valid;
  logic        ena_prev;
  time_t       edge_clk;

  always #20 clk = ~clk; // 40 ns period

  qpu_exu u_dut (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_valid       (i_valid),
    .i_instr       (i_instr),
    .i_trigger     (i_trigger),
    .i_trigger_clk (i_trigger_clk),
    .o_ready       (o_ready),
    .o_clk_ena     (o_clk_ena),
    .o_event_valid (o_event_valid),
    .o_event_data  (o_event_data)
  );

  ////////////////////////////////////////
  // Cycle limit and counter capture
  always @(posedge clk) begin
    cycles   <= cycles + 1;
    edge_clk <= i_trigger_clk; // Counter value seen by the pop edge
    if (limit > 0 && cycles > limit) begin
      $display("Run stopped, cycle limit of %0d reached before all events arrived", limit);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // External time counter
  always @(negedge clk) begin
    if (i_reset) i_trigger_clk <= '0; // Cleared while reset is held
    else if (o_clk_ena) i_trigger_clk <= i_trigger_clk + 1;
  end

  ////////////////////////////////////////
  // Event monitor
  always @(negedge clk) begin
    if (!i_reset && o_event_valid != '0) begin
      if (!ena_prev) begin
        $display("Event released while the time counter was disabled");
        err_cnt[4]++;
      end
      if (prev_valid) begin
        $display("Event pulse lasted longer than one cycle");
        err_cnt[3]++;
      end
      if (ev_idx >= exp_time.size()) begin
        $display("Unexpected extra event, mask %h", o_event_valid);
        err_cnt[3]++;
      end else begin
        if (o_event_valid != exp_mask[ev_idx]) begin
          $display("Error: o_event_valid got %h expected %h", o_event_valid, exp_mask[ev_idx]);
          err_cnt[exp_test[ev_idx]]++;
        end
        if (o_event_data != exp_data[ev_idx]) begin
          $display("Error: o_event_data got %h expected %h", o_event_data, exp_data[ev_idx]);
          err_cnt[exp_test[ev_idx]]++;
        end
        if (edge_clk < exp_time[ev_idx]) begin
          $display("Error: i_trigger_clk at release %h below time %h", edge_clk,
                   exp_time[ev_idx]);
          err_cnt[exp_test[ev_idx]]++;
        end
        ev_idx++;
      end
    end
    prev_valid = !i_reset && (o_event_valid != '0);
    ena_prev   = o_clk_ena;
  end

  task automatic apply_reset();
    @(negedge clk);
    i_reset       = 1'b1;
    i_valid       = 1'b0;
    i_trigger     = 1'b0;
    repeat (10) @(negedge clk);
    i_reset   = 1'b0;
    triggered = 1'b0;
  endtask

  task automatic pulse_trigger();
    i_trigger = 1'b1;
    triggered = 1'b1;
    @(negedge clk);
    i_trigger = 1'b0;
  endtask

  // Presents one word and holds it until accepted
  task automatic issue_instr(input int tid, input logic [31:0] word, input logic stall);
    int gap;
    if (tid == 5) begin
      gap = $random(seed) & 3;
      repeat (gap) @(negedge clk);
    end
    i_valid = 1'b1;
    i_instr = word;
    if (stall) begin
      if (o_ready !== 1'b0) begin
        $display("o_ready stayed high although the queue should be full");
        err_cnt[4]++;
      end
      // Counter beyond every queued time while still disabled
      i_trigger_clk = '1;
      repeat (3) @(negedge clk);
      i_trigger_clk = '0;
      pulse_trigger();
    end else if (o_ready !== 1'b1) begin
      $display("Instruction %h stalled although the queue had room", word);
      err_cnt[tid]++;
    end
    while (o_ready !== 1'b1) @(negedge clk);
    @(negedge clk); // Accept edge has passed
    i_valid = 1'b0;
  endtask

  task automatic finish_run();
    if (!triggered) pulse_trigger();
    while (ev_idx < exp_time.size()) @(negedge clk);
    repeat (4) @(negedge clk);
    for (int t = 1; t < NTEST; t++) begin
      if (used[t] && !reported[t]) begin
        $display("Test %0d %s with %0d errors", t, (err_cnt[t] == 0) ? "passed" : "failed",
                 err_cnt[t]);
        reported[t] = 1'b1;
      end
    end
    exp_time.delete();
    exp_mask.delete();
    exp_data.delete();
    exp_test.delete();
    ev_idx = 0;
    apply_reset();
  endtask

  ////////////////////////////////////////
  // Main sequence
  initial begin
    int kind;
    int tid;
    int n_pass;
    int n_fail;
    i_reset       = 1'b1;
    i_valid       = 1'b0;
    i_instr       = '0;
    i_trigger     = 1'b0;
    i_trigger_clk = '0;
    seed          = 32'h76f637e6;
    cycles        = 0;
    limit         = 0;
    ev_idx        = 0;
    triggered     = 1'b0;
    prev_valid    = 1'b0;
    ena_prev      = 1'b0;
    for (int t = 0; t < NTEST; t++) begin
      err_cnt[t]  = 0;
      used[t]     = 1'b0;
      reported[t] = 1'b0;
    end
    for (int i = 0; i < MAX_REC*REC_W; i++) vec[i] = '0;
    $readmemh("qpu_exu_vectors.txt", vec);
    n_rec = 0;
    while (n_rec < MAX_REC && vec[n_rec*REC_W] != 0) n_rec++;
    limit = 40 * n_rec + 500;

    apply_reset();
    used[1] = 1'b1;
    if (o_ready !== 1'b1 || o_clk_ena !== 1'b0 || o_event_valid !== '0) begin
      $display("Error: after reset o_ready %h o_clk_ena %h o_event_valid %h",
               o_ready, o_clk_ena, o_event_valid);
      err_cnt[1]++;
    end
    $display("Test 1 %s with %0d errors", (err_cnt[1] == 0) ? "passed" : "failed", err_cnt[1]);
    reported[1] = 1'b1;

    for (int r = 0; r < n_rec; r++) begin
      kind = int'(vec[r*REC_W]);
      tid  = int'(vec[r*REC_W+1]);
      if (tid > 0 && tid < NTEST) used[tid] = 1'b1;
      case (kind)
        1: issue_instr(tid, vec[r*REC_W+2], vec[r*REC_W+3][0]);
        2: begin
          exp_time.push_back(vec[r*REC_W+2]);
          exp_mask.push_back(vec[r*REC_W+3][EVENT_NUM-1:0]);
          exp_data.push_back(vec[r*REC_W+4][EVENT_DATA_W-1:0]);
          exp_test.push_back(tid);
        end
        3: finish_run();
        default: begin
          $display("Unknown record kind %0d in vector file", kind);
          used[0] = 1'b1;
          err_cnt[0]++;
        end
      endcase
    end

    n_pass = 0;
    n_fail = 0;
    for (int t = 0; t < NTEST; t++) begin
      if (used[t]) begin
        if (err_cnt[t] == 0) n_pass++;
        else n_fail++;
      end
    end
    $display("Tests passed %0d failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- qpu_exu.sv
`timescale 1ns/1ps

module qpu_exu (
  input  logic                  clk,
  input  logic                  i_reset,
  input  logic                  i_valid,
  input  qpu_pkg::instr_t       i_instr,
  input  logic                  i_trigger,
  input  qpu_pkg::time_t        i_trigger_clk,
  output logic                  o_ready,
  output logic                  o_clk_ena,
  output qpu_pkg::event_mask_t  o_event_valid,
  output qpu_pkg::event_data_t  o_event_data
);

  import qpu_pkg::*;

  dec_info_t   dec;
  xlen_t       rs1;
  xlen_t       rs2;
  time_t       cur_time;
  event_mask_t cur_emask;
  event_data_t cur_edata;
  rf_wbck_t    rf_wbck;
  time_wbck_t  time_wbck;
  event_wbck_t event_wbck;
  logic        tiq_push;
  tiq_entry_t  tiq_entry;
  logic        tiq_full;
  logic        accept;

  // Stall every instruction while the queue is full
  assign o_ready = ~tiq_full;
  assign accept  = i_valid & ~tiq_full;

  ////////////////////////////////////////
  // Decode and operand read
  qpu_exu_decode u_decode (
    .i_instr (i_instr),
    .o_dec   (dec)
  );

  qpu_exu_regfile u_regfile (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_rs1idx     (dec.rs1),
    .i_rs2idx     (dec.rs2),
    .i_rf_wbck    (rf_wbck),
    .i_time_wbck  (time_wbck),
    .i_event_wbck (event_wbck),
    .o_rs1        (rs1),
    .o_rs2        (rs2),
    .o_time       (cur_time),
    .o_event_mask (cur_emask),
    .o_event_data (cur_edata)
  );

  ////////////////////////////////////////
  // Execute and time point push
  qpu_exu_alu u_alu (
    .i_accept     (accept),
    .i_dec        (dec),
    .i_rs1        (rs1),
    .i_rs2        (rs2),
    .i_time       (cur_time),
    .i_event_mask (cur_emask),
    .i_event_data (cur_edata),
    .o_rf_wbck    (rf_wbck),
    .o_time_wbck  (time_wbck),
    .o_event_wbck (event_wbck),
    .o_tiq_push   (tiq_push),
    .o_tiq_entry  (tiq_entry)
  );

  qpu_exu_queue u_queue (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_push        (tiq_push),
    .i_entry       (tiq_entry),
    .i_trigger     (i_trigger),
    .i_trigger_clk (i_trigger_clk),
    .o_full        (tiq_full),
    .o_clk_ena     (o_clk_ena),
    .o_event_valid (o_event_valid),
    .o_event_data  (o_event_data)
  );

endmodule

//--- qpu_exu_queue.sv
`timescale 1ns/1ps

module qpu_exu_queue (
  input  logic                  clk,
  input  logic                  i_reset,
  input  logic                  i_push,
  input  qpu_pkg::tiq_entry_t   i_entry,
  input  logic                  i_trigger,
  input  qpu_pkg::time_t        i_trigger_clk,
  output logic                  o_full,
  output logic                  o_clk_ena,
  output qpu_pkg::event_mask_t  o_event_valid,
  output qpu_pkg::event_data_t  o_event_data
);

  import qpu_pkg::*;

  tiq_entry_t           mem_q [TIQ_DEPTH];
  logic [TIQ_PTR_W-1:0] wptr_q;
  logic [TIQ_PTR_W-1:0] rptr_q;
  logic [TIQ_CNT_W-1:0] count_q;
  logic                 clk_ena_q;
  event_mask_t          ev_valid_q;
  event_data_t          ev_data_q;
  tiq_entry_t           head;
  logic                 empty;
  logic                 push_ok;
  logic                 pop;

  // Wrapping pointer increment
  function automatic logic [TIQ_PTR_W-1:0] ptr_next(input logic [TIQ_PTR_W-1:0] ptr);
    ptr_next = (ptr == TIQ_PTR_W'(TIQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  ////////////////////////////////////////
  // Status and handshake
  assign o_full  = (count_q == TIQ_CNT_W'(TIQ_DEPTH));
  assign empty   = (count_q == '0);
  assign push_ok = i_push & ~o_full;
  assign head    = mem_q[rptr_q];

  // Head leaves once the counter has reached its time
  assign pop = clk_ena_q & ~empty & (i_trigger_clk >= head.tval);

  ////////////////////////////////////////
  // Storage
  always_ff @(posedge clk) begin
    if (push_ok) mem_q[wptr_q] <= i_entry;
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push_ok) wptr_q <= ptr_next(wptr_q);
      if (pop) rptr_q <= ptr_next(rptr_q);
      case ({push_ok, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ; // Both or neither, level unchanged
      endcase
    end
  end

  ////////////////////////////////////////
  // Counter enable and event release
  always_ff @(posedge clk) begin
    if (i_reset) begin
      clk_ena_q  <= 1'b0;
      ev_valid_q <= '0;
    end else begin
      clk_ena_q  <= clk_ena_q | i_trigger; // Sticky after start pulse
      ev_valid_q <= pop ? head.mask : '0;  // Single cycle pulse
    end
  end

  always_ff @(posedge clk) begin
    if (pop) ev_data_q <= head.data;
  end

  assign o_clk_ena     = clk_ena_q;
  assign o_event_valid = ev_valid_q;
  assign o_event_data  = ev_data_q;

endmodule

//--- qpu_exu_alu.sv
`timescale 1ns/1ps

module qpu_exu_alu (
  input  logic                  i_accept,
  input  qpu_pkg::dec_info_t    i_dec,
  input  qpu_pkg::xlen_t        i_rs1,
  input  qpu_pkg::xlen_t        i_rs2,
  input  qpu_pkg::time_t        i_time,
  input  qpu_pkg::event_mask_t  i_event_mask,
  input  qpu_pkg::event_data_t  i_event_data,
  output qpu_pkg::rf_wbck_t     o_rf_wbck,
  output qpu_pkg::time_wbck_t   o_time_wbck,
  output qpu_pkg::event_wbck_t  o_event_wbck,
  output logic                  o_tiq_push,
  output qpu_pkg::tiq_entry_t   o_tiq_entry
);

  import qpu_pkg::*;

  xlen_t imm_sext;
  xlen_t imm_upper;
  xlen_t result;

  assign imm_sext  = {{(XLEN - IMM_W){i_dec.imm[IMM_W-1]}}, i_dec.imm};
  assign imm_upper = {i_dec.imm, {(XLEN - IMM_W){1'b0}}};

  ////////////////////////////////////////
  // Arithmetic
  always_comb begin
    case (i_dec.op)
      OP_ADDI: result = i_rs1 + imm_sext;
      OP_ADD:  result = i_rs1 + i_rs2;
      OP_SUB:  result = i_rs1 - i_rs2;
      OP_LUI:  result = imm_upper;
      default: result = '0;
    endcase
  end

  // Classic write back, decoder already blocks x0
  always_comb begin
    o_rf_wbck.wen  = i_accept & i_dec.rdwen;
    o_rf_wbck.idx  = i_dec.rd;
    o_rf_wbck.data = result;
  end

  ////////////////////////////////////////
  // Timing side
  always_comb begin
    o_time_wbck.wen  = i_accept && (i_dec.op == OP_SETT);
    o_time_wbck.data = time_t'(i_rs1) + time_t'(i_dec.imm); // Zero extended offset

    o_event_wbck.wen  = i_accept && (i_dec.op == OP_SETE);
    o_event_wbck.mask = i_dec.imm[EVENT_NUM-1:0];
    o_event_wbck.data = i_rs1[EVENT_DATA_W-1:0];
  end

  // Time point snapshots the current registers
  assign o_tiq_push = i_accept && (i_dec.op == OP_TPT);

  always_comb begin
    o_tiq_entry.tval = i_time;
    o_tiq_entry.mask = i_event_mask;
    o_tiq_entry.data = i_event_data;
  end

endmodule

//--- qpu_exu_regfile.sv
`timescale 1ns/1ps

module qpu_exu_regfile (
  input  logic                  clk,
  input  logic                  i_reset,
  input  qpu_pkg::rfidx_t       i_rs1idx,
  input  qpu_pkg::rfidx_t       i_rs2idx,
  input  qpu_pkg::rf_wbck_t     i_rf_wbck,
  input  qpu_pkg::time_wbck_t   i_time_wbck,
  input  qpu_pkg::event_wbck_t  i_event_wbck,
  output qpu_pkg::xlen_t        o_rs1,
  output qpu_pkg::xlen_t        o_rs2,
  output qpu_pkg::time_t        o_time,
  output qpu_pkg::event_mask_t  o_event_mask,
  output qpu_pkg::event_data_t  o_event_data
);

  import qpu_pkg::*;

  xlen_t       rf_q [RF_NUM];
  time_t       time_q;
  event_mask_t emask_q;
  event_data_t edata_q;

  ////////////////////////////////////////
  // Classic registers
  always_ff @(posedge clk) begin
    if (i_reset) begin
      for (int i = 0; i < RF_NUM; i++) begin
        rf_q[i] <= '0;
      end
    end else if (i_rf_wbck.wen && (i_rf_wbck.idx != '0)) begin
      rf_q[i_rf_wbck.idx] <= i_rf_wbck.data; // Entry 0 stays at reset value
    end
  end

  assign o_rs1 = rf_q[i_rs1idx];
  assign o_rs2 = rf_q[i_rs2idx];

  ////////////////////////////////////////
  // Time and event registers
  always_ff @(posedge clk) begin
    if (i_reset) begin
      time_q  <= '0;
      emask_q <= '0;
      edata_q <= '0;
    end else begin
      if (i_time_wbck.wen) time_q <= i_time_wbck.data;
      if (i_event_wbck.wen) begin
        emask_q <= i_event_wbck.mask;
        edata_q <= i_event_wbck.data;
      end
    end
  end

  assign o_time       = time_q;
  assign o_event_mask = emask_q;
  assign o_event_data = edata_q;

endmodule

//--- qpu_exu_decode.sv
`timescale 1ns/1ps

module qpu_exu_decode (
  input  qpu_pkg::instr_t    i_instr,
  output qpu_pkg::dec_info_t o_dec
);

  import qpu_pkg::*;

  logic [OPC_W-1:0] raw_op;
  opcode_e          op;
  rfidx_t           rd;
  rfidx_t           rs1;
  rfidx_t           rs2;
  logic [IMM_W-1:0] imm;
  logic             writes_rd;

  ////////////////////////////////////////
  // Field slicing
  assign raw_op = i_instr[OPC_LSB +: OPC_W];
  assign rd     = i_instr[RD_LSB +: RFIDX_W];
  assign rs1    = i_instr[RS1_LSB +: RFIDX_W];
  assign rs2    = i_instr[RS2_LSB +: RFIDX_W];
  assign imm    = i_instr[IMM_LSB +: IMM_W];

  // Unused encodings fall back to NOP
  always_comb begin
    case (raw_op)
      OP_ADDI,
      OP_ADD,
      OP_SUB,
      OP_LUI,
      OP_SETT,
      OP_SETE,
      OP_TPT:  op = opcode_e'(raw_op);
      default: op = OP_NOP;
    endcase
  end

  // Only the arithmetic group targets rd
  always_comb begin
    case (op)
      OP_ADDI,
      OP_ADD,
      OP_SUB,
      OP_LUI:  writes_rd = 1'b1;
      default: writes_rd = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Decoded info bus
  always_comb begin
    o_dec.op    = op;
    o_dec.rd    = rd;
    o_dec.rs1   = rs1;
    o_dec.rs2   = rs2;
    o_dec.imm   = imm;
    o_dec.rdwen = writes_rd && (rd != '0); // x0 is never written
  end

endmodule

//--- qpu_pkg.sv
package qpu_pkg;

  ////////////////////////////////////////
  // Sizes
  localparam int XLEN         = 32;
  localparam int RF_NUM       = 16;
  localparam int RFIDX_W      = 4;
  localparam int TIME_W       = 32;
  localparam int EVENT_NUM    = 8;
  localparam int EVENT_DATA_W = 16;
  localparam int TIQ_DEPTH    = 4;
  localparam int IMM_W        = 16;

  localparam int TIQ_PTR_W    = $clog2(TIQ_DEPTH);
  localparam int TIQ_CNT_W    = $clog2(TIQ_DEPTH + 1); // Needs to hold TIQ_DEPTH itself

  ////////////////////////////////////////
  // Instruction word layout
  localparam int INSTR_W = 32;
  localparam int OPC_W   = 4;
  localparam int OPC_LSB = 28;
  localparam int RD_LSB  = 24;
  localparam int RS1_LSB = 20;
  localparam int RS2_LSB = 16;
  localparam int IMM_LSB = 0;

  typedef logic [INSTR_W-1:0]      instr_t;
  typedef logic [XLEN-1:0]         xlen_t;
  typedef logic [RFIDX_W-1:0]      rfidx_t;
  typedef logic [TIME_W-1:0]       time_t;
  typedef logic [EVENT_NUM-1:0]    event_mask_t;
  typedef logic [EVENT_DATA_W-1:0] event_data_t;

  typedef enum logic [OPC_W-1:0] {
    OP_NOP  = 4'h0,
    OP_ADDI = 4'h1, // rd = rs1 + sext(imm)
    OP_ADD  = 4'h2,
    OP_SUB  = 4'h3,
    OP_LUI  = 4'h4, // rd = imm << 16
    OP_SETT = 4'h5, // time = rs1 + zext(imm)
    OP_SETE = 4'h6, // mask = imm[7:0], data = rs1[15:0]
    OP_TPT  = 4'h7  // Push time point
  } opcode_e;

  ////////////////////////////////////////
  // Structs between the stage blocks
  typedef struct packed {
    opcode_e          op;
    rfidx_t           rd;
    rfidx_t           rs1;
    rfidx_t           rs2;
    logic [IMM_W-1:0] imm;
    logic             rdwen;
  } dec_info_t;

  typedef struct packed {
    logic   wen;
    rfidx_t idx;
    xlen_t  data;
  } rf_wbck_t;

  typedef struct packed {
    logic  wen;
    time_t data;
  } time_wbck_t;

  typedef struct packed {
    logic        wen;
    event_mask_t mask;
    event_data_t data;
  } event_wbck_t;

  // One timing queue slot, tval is the release time
  typedef struct packed {
    time_t       tval;
    event_mask_t mask;
    event_data_t data;
  } tiq_entry_t;

endpackage
